//--- tb.f
+incdir+hdl
hdl/pic_pkg.sv
hdl/pic_cfg_if.sv
hdl/pic_regs.sv
hdl/pic_edge_detect.sv
hdl/pic_prio_enc.sv
hdl/pic_top.sv
test/tb_clock_gen.sv
test/pic_assertions.sv
test/pic_tb.sv

//--- test/pic_tb.sv
`include "pic_config.svh"

module pic_tb;

	// the whole run needs well under 600 cycles, limit leaves ample margin
	localparam int timeout_cycles = 3000;

	logic clk;
	logic rst_i;
	logic req_valid_i;
	logic req_ready_o;
	logic req_write_i;
	logic [`PIC_ADDR_W-1:0] req_addr_i;
	logic [31:0] req_wdata_i;
	logic rsp_valid_o;
	logic [31:0] rsp_rdata_o;
	logic rsp_ready_i;
	logic [`PIC_NUM_IRQ-1:0] irq_i;
	logic [3:0] irq_level_o;
	logic [7:0] cause_o;
	logic [5:0] core_o;
	logic nmi_o;
	logic [31:0] lfsr_q;
	int cycle_cnt = 0;

	tb_clock_gen i_clk_gen (
		.clk   (clk),
		.rst_o (rst_i)
	);

	pic_top i_dut (
		.clk         (clk),
		.rst_i       (rst_i),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_write_i (req_write_i),
		.req_addr_i  (req_addr_i),
		.req_wdata_i (req_wdata_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_rdata_o (rsp_rdata_o),
		.rsp_ready_i (rsp_ready_i),
		.irq_i       (irq_i),
		.irq_level_o (irq_level_o),
		.cause_o     (cause_o),
		.core_o      (core_o),
		.nmi_o       (nmi_o)
	);

	// ==============================
	// helpers
	// ==============================

	// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int n = 0; n < nbits; n++)
		begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	// global registers sit at word offsets with addr[7] low
	function automatic logic [7:0] reg_addr(input pic_pkg::pic_reg_e r);
		return {1'b0, r, 2'b00};
	endfunction

	function automatic logic [7:0] ctl_addr(input int line);
		return {1'b1, 5'(line), 2'b00};
	endfunction

	// control word layout: cause 7:0, level 11:8, enable 16, edge 17, core 29:24
	function automatic logic [31:0] ctl_word(input pic_pkg::pic_irq_ctl_t c,
		input logic en, input logic edge_s);
		return {2'b00, c.core, 6'b000000, edge_s, en, 4'b0000, c.level, c.cause};
	endfunction

	// what the outputs show for a winner, level masked when disabled
	function automatic pic_pkg::pic_irq_ctl_t shown_ctl(input pic_pkg::pic_irq_ctl_t c,
		input logic en);
		pic_pkg::pic_irq_ctl_t r;
		r = c;
		if (!en)
			r.level = 4'h0;
		return r;
	endfunction

	task automatic report_fail(input string msg);
		$display("[FAIL] t=%0t %s", $time, msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			report_fail($sformatf("%s: got %08h expected %08h", what, got, exp));
	endtask

	task automatic check_ctl(input string what, input pic_pkg::pic_irq_ctl_t exp,
		input logic exp_nmi);
		if (irq_level_o !== exp.level || cause_o !== exp.cause || core_o !== exp.core
			|| nmi_o !== exp_nmi)
			report_fail($sformatf("%s: lvl/cause/core/nmi got %0h/%02h/%02h/%b exp %0h/%02h/%02h/%b",
				what, irq_level_o, cause_o, core_o, nmi_o,
				exp.level, exp.cause, exp.core, exp_nmi));
	endtask

	// outputs are given 6 cycles to settle after any stimulus
	task automatic settle();
		repeat (6) @(negedge clk);
	endtask

	// ==============================
	// bus tasks
	// ==============================

	task automatic bus_xfer(input logic wr, input logic [7:0] addr,
		input logic [31:0] wdata, input int stall, output logic [31:0] rdata);
		logic [31:0] held;
		@(negedge clk);
		req_valid_i = 1'b1;
		req_write_i = wr;
		req_addr_i = addr;
		req_wdata_i = wdata;
		rsp_ready_i = 1'b0;
		// ready only moves on a rising edge, so this value holds into the next one
		while (!req_ready_o)
			@(negedge clk);
		@(negedge clk);
		req_valid_i = 1'b0;
		req_write_i = 1'b0;
		while (!rsp_valid_o)
			@(negedge clk);
		held = rsp_rdata_o;
		// back-pressure, response must hold
		for (int n = 0; n < stall; n++)
		begin
			@(negedge clk);
			if (!rsp_valid_o)
				report_fail("response valid dropped during a stall");
			check_word("stalled response data", rsp_rdata_o, held);
		end
		rsp_ready_i = 1'b1;
		@(negedge clk);
		rsp_ready_i = 1'b0;
		rdata = held;
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		bus_xfer(1'b1, addr, data, 0, rd);
		check_word("write response", rd, 32'h0);
	endtask

	task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
		int stall;
		stall = int'(lfsr_take(3));
		bus_xfer(1'b0, addr, 32'h0, stall, data);
	endtask

	// ==============================
	// directed tests
	// ==============================

	task automatic test_reset_state();
		logic [31:0] rd;
		pic_pkg::pic_irq_ctl_t rst_ctl;
		rst_ctl = '{cause: 8'h00, level: `PIC_RST_LEVEL, core: 6'h00};
		if (!req_ready_o || rsp_valid_o)
			report_fail("bus is not idle after reset");
		check_ctl("outputs after reset", '0, 1'b0);
		bus_read(reg_addr(pic_pkg::REG_ENABLE), rd);
		check_word("enable after reset", rd, 32'h0);
		// every line comes up disabled and edge sensitive
		bus_read(ctl_addr(5), rd);
		check_word("line 5 control after reset", rd, ctl_word(rst_ctl, 1'b0, 1'b1));
	endtask

	task automatic test_enable_regs();
		logic [31:0] rd;
		logic [31:0] exp;
		logic [4:0] bit_n;
		exp = lfsr_take(32);
		bit_n = 5'(lfsr_take(5));
		// chosen bit starts clear so both the set and the clear move it
		exp[bit_n] = 1'b0;
		bus_write(reg_addr(pic_pkg::REG_ENABLE), exp);
		bus_read(reg_addr(pic_pkg::REG_ENABLE), rd);
		check_word("enable write", rd, exp);
		exp[bit_n] = 1'b1;
		bus_write(reg_addr(pic_pkg::REG_EN_SET), {27'h0, bit_n});
		bus_read(reg_addr(pic_pkg::REG_ENABLE), rd);
		check_word("enable set", rd, exp);
		exp[bit_n] = 1'b0;
		bus_write(reg_addr(pic_pkg::REG_EN_CLR), {27'h0, bit_n});
		bus_read(reg_addr(pic_pkg::REG_ENABLE), rd);
		check_word("enable clear", rd, exp);
		// back to all disabled for the later tests
		bus_write(reg_addr(pic_pkg::REG_ENABLE), 32'h0);
		bus_read(reg_addr(pic_pkg::REG_ENABLE), rd);
		check_word("enable cleared", rd, 32'h0);
	endtask

	task automatic test_level_priority();
		pic_pkg::pic_irq_ctl_t c3;
		pic_pkg::pic_irq_ctl_t c9;
		c3 = '{cause: 8'h33, level: 4'h5, core: 6'h03};
		c9 = '{cause: 8'h99, level: 4'h7, core: 6'h09};
		// level sensitive and enabled
		bus_write(ctl_addr(3), ctl_word(c3, 1'b1, 1'b0));
		bus_write(ctl_addr(9), ctl_word(c9, 1'b1, 1'b0));
		@(negedge clk);
		irq_i[3] = 1'b1;
		irq_i[9] = 1'b1;
		settle();
		check_ctl("line 3 wins over 9", shown_ctl(c3, 1'b1), 1'b0);
		irq_i[3] = 1'b0;
		settle();
		check_ctl("line 9 after 3 drops", shown_ctl(c9, 1'b1), 1'b0);
		bus_write(reg_addr(pic_pkg::REG_EN_CLR), 32'd9);
		settle();
		check_ctl("line 9 disabled", shown_ctl(c9, 1'b0), 1'b0);
		irq_i[9] = 1'b0;
		settle();
		check_ctl("no level line pending", '0, 1'b0);
	endtask

	task automatic test_edge_latch();
		pic_pkg::pic_irq_ctl_t c12;
		c12 = '{cause: 8'hc1, level: 4'h3, core: 6'h0c};
		bus_write(ctl_addr(12), ctl_word(c12, 1'b1, 1'b1));
		// one-cycle pulse
		@(negedge clk);
		irq_i[12] = 1'b1;
		@(negedge clk);
		irq_i[12] = 1'b0;
		settle();
		check_ctl("edge line 12 latched", shown_ctl(c12, 1'b1), 1'b0);
		bus_write(reg_addr(pic_pkg::REG_EDGE_RST), 32'd12);
		settle();
		check_ctl("edge line 12 cleared", '0, 1'b0);
	endtask

	task automatic test_soft_trigger();
		logic [31:0] rd;
		pic_pkg::pic_irq_ctl_t c20;
		c20 = '{cause: 8'h5a, level: 4'h2, core: 6'h14};
		bus_write(ctl_addr(20), ctl_word(c20, 1'b1, 1'b1));
		settle();
		check_ctl("line 20 idle before trigger", '0, 1'b0);
		bus_write(reg_addr(pic_pkg::REG_TRIGGER), 32'd20);
		settle();
		check_ctl("line 20 triggered", shown_ctl(c20, 1'b1), 1'b0);
		bus_read(reg_addr(pic_pkg::REG_STATUS), rd);
		check_word("status shows line 20 cause", rd, {24'h0, c20.cause});
		bus_write(reg_addr(pic_pkg::REG_EDGE_RST), 32'd20);
		settle();
		check_ctl("line 20 cleared", '0, 1'b0);
		bus_read(reg_addr(pic_pkg::REG_STATUS), rd);
		check_word("status with no winner", rd, 32'h0);
	endtask

	task automatic test_nmi_gate();
		@(negedge clk);
		irq_i[0] = 1'b1;
		settle();
		check_ctl("nmi masked", '0, 1'b0);
		bus_write(reg_addr(pic_pkg::REG_EN_SET), 32'd0);
		settle();
		check_ctl("nmi enabled", '0, 1'b1);
		irq_i[0] = 1'b0;
		settle();
		check_ctl("nmi input low", '0, 1'b0);
		irq_i[0] = 1'b1;
		bus_write(reg_addr(pic_pkg::REG_EN_CLR), 32'd0);
		settle();
		check_ctl("nmi disabled again", '0, 1'b0);
		irq_i[0] = 1'b0;
	endtask

	// ==============================
	// run control
	// ==============================

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_cycles)
		begin
			$display("timeout: the tests did not finish within %0d cycles",
				timeout_cycles);
			$display("Regression failed");
			$fatal(1);
		end
	end

	initial
	begin
		req_valid_i = 1'b0;
		req_write_i = 1'b0;
		req_addr_i = '0;
		req_wdata_i = '0;
		rsp_ready_i = 1'b0;
		irq_i = '0;
		lfsr_q = 32'h3f3e;
		@(negedge clk);
		while (rst_i)
			@(negedge clk);
		test_reset_state();
		test_enable_regs();
		test_level_priority();
		test_edge_latch();
		test_soft_trigger();
		test_nmi_gate();
		$display("Regression passed");
		$finish;
	end

endmodule

//--- test/pic_assertions.sv
`include "pic_config.svh"

module pic_assertions (
	input logic                   clk,
	input logic                   rst_i,
	input logic                   req_valid_i,
	input logic                   req_ready_o,
	input logic                   req_write_i,
	input logic [`PIC_ADDR_W-1:0] req_addr_i,
	input logic                   rsp_valid_o,
	input logic [31:0]            rsp_rdata_o,
	input logic                   rsp_ready_i,
	input logic [3:0]             irq_level_o,
	input logic [7:0]             cause_o
);

	// set once any control word has been written
	logic ctl_written;

	always_ff @(posedge clk)
	begin
		if (rst_i)
			ctl_written <= 1'b0;
		else if (req_valid_i && req_ready_o && req_write_i && req_addr_i[7])
			ctl_written <= 1'b1;
	end

	// ==============================
	// bus protocol
	// ==============================

	// an accepted request is answered on the next edge with ready low
	ready_vs_valid: assert property (@(posedge clk) disable iff (rst_i)
		(req_valid_i && req_ready_o) |=> (rsp_valid_o && !req_ready_o))
		else $error("accepted request got no response or a second request was taken");

	// response holds under back-pressure
	rsp_hold: assert property (@(posedge clk) disable iff (rst_i)
		(rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_rdata_o)))
		else $error("response changed while stalled");

	// ==============================
	// outputs
	// ==============================

	// unprogrammed lines never raise a level without a cause
	quiet_level: assert property (@(posedge clk) disable iff (rst_i)
		(!ctl_written && cause_o == 8'h00) |-> (irq_level_o == 4'h0))
		else $error("level raised with no cause before any line was programmed");

endmodule

bind pic_top pic_assertions i_checks (
	.clk         (clk),
	.rst_i       (rst_i),
	.req_valid_i (req_valid_i),
	.req_ready_o (req_ready_o),
	.req_write_i (req_write_i),
	.req_addr_i  (req_addr_i),
	.rsp_valid_o (rsp_valid_o),
	.rsp_rdata_o (rsp_rdata_o),
	.rsp_ready_i (rsp_ready_i),
	.irq_level_o (irq_level_o),
	.cause_o     (cause_o)
);

//--- test/tb_clock_gen.sv
module tb_clock_gen (
	output logic clk,
	output logic rst_o
);

	// period of 4 time units
	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// reset held for 8 cycles, released on a falling edge
	initial
	begin
		rst_o = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_o = 1'b0;
	end

endmodule

//--- hdl/pic_top.sv
`include "pic_config.svh"

module pic_top (
	input  logic                    clk,
	input  logic                    rst_i,
	// request channel
	input  logic                    req_valid_i,
	output logic                    req_ready_o,
	input  logic                    req_write_i,
	input  logic [`PIC_ADDR_W-1:0]  req_addr_i,
	input  logic [31:0]             req_wdata_i,
	// response channel
	output logic                    rsp_valid_o,
	output logic [31:0]             rsp_rdata_o,
	input  logic                    rsp_ready_i,
	// request lines, bit 0 is nmi
	input  logic [`PIC_NUM_IRQ-1:0] irq_i,
	// to the processor
	output logic [3:0]              irq_level_o,
	output logic [7:0]              cause_o,
	output logic [5:0]              core_o,
	output logic                    nmi_o
);

	// edge latches toward the encoder
	logic [`PIC_NUM_IRQ-1:0] pending;

	// configuration and winner shared by the three blocks
	pic_cfg_if cfg_if ();

	// ==============================
	// blocks
	// ==============================

	// bus slave and register file
	pic_regs u_regs (
		.clk         (clk),
		.rst_i       (rst_i),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_write_i (req_write_i),
		.req_addr_i  (req_addr_i),
		.req_wdata_i (req_wdata_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_rdata_o (rsp_rdata_o),
		.rsp_ready_i (rsp_ready_i),
		.cfg         (cfg_if)
	);

	pic_edge_detect u_edge (
		.clk           (clk),
		.irq_i         (irq_i),
		.cfg           (cfg_if),
		.pending_raw_o (pending)
	);

	// winner pick and registered outputs
	pic_prio_enc u_enc (
		.clk          (clk),
		.rst_i        (rst_i),
		.irq_i        (irq_i),
		.edge_latch_i (pending),
		.cfg          (cfg_if),
		.irq_level_o  (irq_level_o),
		.cause_o      (cause_o),
		.core_o       (core_o),
		.nmi_o        (nmi_o)
	);

endmodule

//--- hdl/pic_prio_enc.sv
`include "pic_config.svh"

module pic_prio_enc (
	input  logic                    clk,
	input  logic                    rst_i,
	input  logic [`PIC_NUM_IRQ-1:0] irq_i,
	input  logic [`PIC_NUM_IRQ-1:0] edge_latch_i,
	pic_cfg_if.enc                  cfg,
	output logic [3:0]              irq_level_o,
	output logic [7:0]              cause_o,
	output logic [5:0]              core_o,
	output logic                    nmi_o
);

	logic [`PIC_NUM_IRQ-1:0] pending;
	logic [`PIC_IDX_W-1:0] winner_d;
	pic_pkg::pic_irq_ctl_t win_ctl;

	// ==============================
	// priority select
	// ==============================

	// edge lines use the latch, level lines the raw input
	assign pending = (cfg.edge_sel & edge_latch_i) | (~cfg.edge_sel & irq_i);

	// scan downward so the lowest pending line is left standing
	always_comb
	begin
		winner_d = '0;
		for (int n = `PIC_NUM_IRQ - 1; n > 0; n--)
		begin
			if (pending[n])
				winner_d = `PIC_IDX_W'(n);
		end
	end

	// enable does not take part in the choice
	always_ff @(posedge clk)
	begin
		if (rst_i)
			cfg.winner <= '0;
		else
			cfg.winner <= winner_d;
	end

	// ==============================
	// output stage
	// ==============================

	assign win_ctl = cfg.ctl[cfg.winner];

	always_ff @(posedge clk)
	begin
		if (rst_i || cfg.winner == '0)
		begin
			irq_level_o <= '0;
			cause_o <= '0;
			core_o <= '0;
		end
		else
		begin
			// a disabled winner still shows its cause, only the level is masked
			irq_level_o <= win_ctl.level & {4{cfg.enable[cfg.winner]}};
			cause_o <= win_ctl.cause;
			core_o <= win_ctl.core;
		end
	end

	// nmi just passes its enable, one cycle late
	always_ff @(posedge clk)
	begin
		if (rst_i)
			nmi_o <= 1'b0;
		else
			nmi_o <= irq_i[0] & cfg.enable[0];
	end

endmodule

//--- hdl/pic_edge_detect.sv
`include "pic_config.svh"

module pic_edge_detect (
	input  logic                    clk,
	input  logic [`PIC_NUM_IRQ-1:0] irq_i,
	pic_cfg_if.edge_det             cfg,
	output logic [`PIC_NUM_IRQ-1:0] pending_raw_o
);

	// line 0 is the nmi and never goes through a latch
	logic [`PIC_NUM_IRQ-1:1] irq_q;
	logic [`PIC_NUM_IRQ-1:1] latch_q;

	// ==============================
	// input history
	// ==============================

	// previous input value, compared against the live input
	always_ff @(posedge clk)
	begin
		irq_q <= irq_i[`PIC_NUM_IRQ-1:1];
	end

	// ==============================
	// edge latches
	// ==============================

	always_ff @(posedge clk)
	begin
		for (int n = 1; n < `PIC_NUM_IRQ; n++)
		begin
			// clear wins over a simultaneous edge or trigger
			if (cfg.edge_rst[n])
				latch_q[n] <= 1'b0;
			else if (cfg.trig[n] || (irq_i[n] && !irq_q[n]))
				latch_q[n] <= 1'b1;
		end
	end

	// bit 0 stays low, nmi has its own path
	assign pending_raw_o = {latch_q, 1'b0};

endmodule

//--- hdl/pic_regs.sv
`include "pic_config.svh"

module pic_regs (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   req_valid_i,
	output logic                   req_ready_o,
	input  logic                   req_write_i,
	input  logic [`PIC_ADDR_W-1:0] req_addr_i,
	input  logic [31:0]            req_wdata_i,
	output logic                   rsp_valid_o,
	output logic [31:0]            rsp_rdata_o,
	input  logic                   rsp_ready_i,
	pic_cfg_if.regs                cfg
);

	pic_pkg::pic_bus_state_e state_q;
	logic accept;
	logic ctl_sel;
	logic [`PIC_IDX_W-1:0] addr_idx;
	logic [`PIC_IDX_W-1:0] data_idx;
	pic_pkg::pic_reg_e reg_off;
	pic_pkg::pic_irq_ctl_t rd_ctl;
	logic [31:0] rd_data;

	// ==============================
	// handshake
	// ==============================

	// ready only while idle, so a single request is ever outstanding
	assign req_ready_o = (state_q == pic_pkg::BUS_IDLE);
	assign rsp_valid_o = (state_q == pic_pkg::BUS_RESP);
	assign accept = req_valid_i && req_ready_o;

	always_ff @(posedge clk)
	begin
		if (rst_i)
			state_q <= pic_pkg::BUS_IDLE;
		else
		begin
			case (state_q)
				pic_pkg::BUS_IDLE:
					if (accept)
						state_q <= pic_pkg::BUS_RESP;
				pic_pkg::BUS_RESP:
					// response holds until the master takes it
					if (rsp_ready_i)
						state_q <= pic_pkg::BUS_IDLE;
				default:
					state_q <= pic_pkg::BUS_IDLE;
			endcase
		end
	end

	// ==============================
	// address decode
	// ==============================

	// addr[7] picks the control word region
	assign ctl_sel = req_addr_i[7];
	assign addr_idx = req_addr_i[`PIC_IDX_W+1:2];
	// set / clear / reset / trigger name a line in the low data bits
	assign data_idx = req_wdata_i[`PIC_IDX_W-1:0];
	assign reg_off = pic_pkg::pic_reg_e'(req_addr_i[6:2]);
	assign rd_ctl = cfg.ctl[addr_idx];

	// read mux, writes always answer with zero
	always_comb
	begin
		rd_data = '0;
		if (!req_write_i)
		begin
			if (ctl_sel)
				rd_data = {2'b00, rd_ctl.core, 6'b000000, cfg.edge_sel[addr_idx],
					cfg.enable[addr_idx], 4'b0000, rd_ctl.level, rd_ctl.cause};
			else if (reg_off == pic_pkg::REG_STATUS)
				rd_data = {24'h000000, cfg.ctl[cfg.winner].cause};
			else
				rd_data = cfg.enable;
		end
	end

	// response data is captured on the accepting edge and held after
	always_ff @(posedge clk)
	begin
		if (rst_i)
			rsp_rdata_o <= '0;
		else if (accept)
			rsp_rdata_o <= rd_data;
	end

	// ==============================
	// register writes
	// ==============================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			cfg.enable <= '0;
			cfg.edge_sel <= `PIC_RST_EDGE_SEL;
			cfg.trig <= '0;
			// keep every edge latch cleared for as long as reset lasts
			cfg.edge_rst <= '1;
			for (int n = 0; n < `PIC_NUM_IRQ; n++)
			begin
				cfg.ctl[n].cause <= '0;
				cfg.ctl[n].level <= `PIC_RST_LEVEL;
				cfg.ctl[n].core <= '0;
			end
		end
		else
		begin
			// pulses last a single cycle
			cfg.trig <= '0;
			cfg.edge_rst <= '0;
			if (accept && req_write_i)
			begin
				if (ctl_sel)
				begin
					// control word also carries enable and edge select
					cfg.ctl[addr_idx].cause <= req_wdata_i[7:0];
					cfg.ctl[addr_idx].level <= req_wdata_i[11:8];
					cfg.ctl[addr_idx].core <= req_wdata_i[29:24];
					cfg.enable[addr_idx] <= req_wdata_i[16];
					cfg.edge_sel[addr_idx] <= req_wdata_i[17];
				end
				else
				begin
					case (reg_off)
						pic_pkg::REG_ENABLE:   cfg.enable <= req_wdata_i;
						pic_pkg::REG_EN_CLR:   cfg.enable[data_idx] <= 1'b0;
						pic_pkg::REG_EN_SET:   cfg.enable[data_idx] <= 1'b1;
						pic_pkg::REG_EDGE_SEL: cfg.edge_sel <= req_wdata_i;
						pic_pkg::REG_EDGE_RST: cfg.edge_rst[data_idx] <= 1'b1;
						pic_pkg::REG_TRIGGER:  cfg.trig[data_idx] <= 1'b1;
						// status and unused offsets ignore writes
						default: ;
					endcase
				end
			end
		end
	end

endmodule

//--- hdl/pic_cfg_if.sv
`include "pic_config.svh"

interface pic_cfg_if;

	// programmed per-line enables
	logic [`PIC_NUM_IRQ-1:0] enable;
	// per-line edge select, set means edge sensitive
	logic [`PIC_NUM_IRQ-1:0] edge_sel;
	// one-cycle software trigger pulses
	logic [`PIC_NUM_IRQ-1:0] trig;
	// one-cycle edge latch clear pulses
	logic [`PIC_NUM_IRQ-1:0] edge_rst;
	// control word of every line
	pic_pkg::pic_irq_ctl_t ctl [`PIC_NUM_IRQ];
	// current winning line, 0 when nothing pending
	logic [`PIC_IDX_W-1:0] winner;

	// register block owns the configuration
	modport regs (
		output enable, edge_sel, trig, edge_rst, ctl,
		input  winner
	);

	// edge latches only see the pulses
	modport edge_det (
		input trig, edge_rst
	);

	// encoder reads config and publishes the winner
	modport enc (
		input  enable, edge_sel, ctl,
		output winner
	);

endinterface

//--- hdl/pic_pkg.sv
package pic_pkg;

	// ==============================
	// register map
	// ==============================

	// word offsets of the global registers, taken from addr[6:2]
	// addr[7] set selects the per-line control words instead
	typedef enum logic [4:0] {
		REG_STATUS   = 5'd0,
		REG_ENABLE   = 5'd1,
		REG_EN_CLR   = 5'd2,
		REG_EN_SET   = 5'd3,
		REG_EDGE_SEL = 5'd4,
		REG_EDGE_RST = 5'd5,
		REG_TRIGGER  = 5'd6
	} pic_reg_e;

	// bus slave state, one transfer in flight at most
	typedef enum logic {
		BUS_IDLE = 1'b0,
		BUS_RESP = 1'b1
	} pic_bus_state_e;

	// ==============================
	// per-line control word
	// ==============================

	// cause code, request level and target core of one line
	typedef struct packed {
		logic [7:0] cause;
		logic [3:0] level;
		logic [5:0] core;
	} pic_irq_ctl_t;

endpackage

//--- hdl/pic_config.svh
`ifndef PIC_CONFIG_SVH
`define PIC_CONFIG_SVH

// ==============================
// controller dimensions
// ==============================

// request lines, line 0 is the nmi
`define PIC_NUM_IRQ 32
// bits needed to index one line
`define PIC_IDX_W 5
// register byte address width
`define PIC_ADDR_W 8

// ==============================
// reset values
// ==============================

// request level of every line out of reset
`define PIC_RST_LEVEL 4'd8
// all lines come up edge sensitive
`define PIC_RST_EDGE_SEL 32'hffff_ffff

`endif
